// File: common/fp_cvt_pkg.sv
package fp_cvt_pkg;

   // ********************
   // operations
   // ********************
   typedef enum logic [1:0] {
      trunc_w_s = 2'd0,
      trunc_w_d = 2'd1,
      cvt_s_w   = 2'd2,
      cvt_d_w   = 2'd3
   } cvt_op_t;

   // ********************
   // format widths and biases
   // ********************
   localparam int sp_exp_w  = 8;
   localparam int sp_frac_w = 23;
   localparam int sp_bias   = 127;

   localparam int dp_exp_w  = 11;
   localparam int dp_frac_w = 52;
   localparam int dp_bias   = 1023;

   localparam int uexp_w = 12;     // unbiased exponent, signed, both formats
   localparam int mant_w = 53;     // hidden bit plus double fraction

   localparam logic [31:0] int_max = 32'h7fffffff;

   // positions in the flags output
   localparam int flag_invalid = 0;
   localparam int flag_inexact = 1;

   // one operand word, read as a double or as a single in the low half
   typedef union packed {
      struct packed {
         logic                 sign;
         logic [dp_exp_w-1:0]  exp;
         logic [dp_frac_w-1:0] frac;
      } d;
      struct packed {
         logic [31:0]          unused;
         logic                 sign;
         logic [sp_exp_w-1:0]  exp;
         logic [sp_frac_w-1:0] frac;
      } s;
   } fp_operand_t;

endpackage

// File: fp_trunc/fp_unpack.sv
`timescale 1ns/100ps

module fp_unpack (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 en,
   input  fp_cvt_pkg::cvt_op_t                  op,
   input  fp_cvt_pkg::fp_operand_t              operand,
   output logic                                 valid_1,
   output fp_cvt_pkg::cvt_op_t                  op_1,
   output logic                                 sign_1,
   output logic signed [fp_cvt_pkg::uexp_w-1:0] exp_1,
   output logic [fp_cvt_pkg::mant_w-1:0]        mant_1,
   output logic                                 is_zero_1,
   output logic                                 is_special_1,
   output logic [31:0]                          int_1
);

   logic                                 f_sign;
   logic signed [fp_cvt_pkg::uexp_w-1:0] f_uexp;
   logic [fp_cvt_pkg::dp_frac_w-1:0]     f_frac;     // left aligned
   logic                                 exp_zero;
   logic                                 exp_ones;

   // ********************
   // field decode
   // ********************
   always_comb
   begin
      if (op == fp_cvt_pkg::trunc_w_d)
      begin
         f_sign   = operand.d.sign;
         f_frac   = operand.d.frac;
         exp_zero = (operand.d.exp == '0);
         exp_ones = &operand.d.exp;
         f_uexp   = fp_cvt_pkg::uexp_w'({1'b0, operand.d.exp})
                    - fp_cvt_pkg::uexp_w'(fp_cvt_pkg::dp_bias);
      end
      else
      begin
         // single in low half, fraction padded on the right
         f_sign   = operand.s.sign;
         f_frac   = {operand.s.frac,
                     {(fp_cvt_pkg::dp_frac_w - fp_cvt_pkg::sp_frac_w){1'b0}}};
         exp_zero = (operand.s.exp == '0);
         exp_ones = &operand.s.exp;
         f_uexp   = fp_cvt_pkg::uexp_w'(operand.s.exp)
                    - fp_cvt_pkg::uexp_w'(fp_cvt_pkg::sp_bias);
      end
   end

   // ********************
   // stage 1 registers
   // ********************
   always_ff @(posedge clk)
   begin
      if (reset)
         valid_1 <= 1'b0;
      else
         valid_1 <= en;
   end

   always_ff @(posedge clk)
   begin
      op_1         <= op;
      sign_1       <= f_sign;
      exp_1        <= f_uexp;
      mant_1       <= {~exp_zero, f_frac};   // subnormals flush to zero
      is_zero_1    <= exp_zero;
      is_special_1 <= exp_ones;               // inf or nan
      int_1        <= operand[31:0];
   end

endmodule

// File: fp_trunc/fp_trunc_to_int32.sv
`timescale 1ns/100ps

module fp_trunc_to_int32 (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 valid_1,
   input  fp_cvt_pkg::cvt_op_t                  op_1,
   input  logic                                 sign_1,
   input  logic signed [fp_cvt_pkg::uexp_w-1:0] exp_1,
   input  logic [fp_cvt_pkg::mant_w-1:0]        mant_1,
   input  logic                                 is_zero_1,
   input  logic                                 is_special_1,
   output logic                                 valid_2,
   output fp_cvt_pkg::cvt_op_t                  op_2,
   output logic [31:0]                          trunc_2,
   output logic                                 trunc_invalid_2,
   output logic                                 trunc_inexact_2
);

   logic                                 exp_neg;
   logic                                 too_big;
   logic [5:0]                           shift_dist;
   logic [fp_cvt_pkg::mant_w+31:0]       mant_pad;
   logic [fp_cvt_pkg::mant_w+31:0]       mant_shift;
   logic [31:0]                          t_mag;
   logic [31:0]                          t_int;
   logic                                 t_invalid;
   logic                                 t_inexact;

   always_comb
   begin
      exp_neg = exp_1[fp_cvt_pkg::uexp_w-1];   // magnitude below one
      too_big = !exp_neg && (exp_1 >= 31);

      // integer part lands in the top 32 bits after the shift
      mant_pad   = {32'd0, mant_1};
      shift_dist = {1'b0, exp_1[4:0]} + 6'd1;
      mant_shift = mant_pad << shift_dist;

      t_mag     = mant_shift[fp_cvt_pkg::mant_w+31:fp_cvt_pkg::mant_w];
      t_int     = '0;
      t_invalid = 1'b0;
      t_inexact = 1'b0;

      if (is_special_1 || too_big)
      begin
         t_int     = fp_cvt_pkg::int_max;
         t_invalid = 1'b1;
      end
      else if (is_zero_1)
      begin
         t_int = '0;
      end
      else if (exp_neg)
      begin
         t_int     = '0;
         t_inexact = 1'b1;   // whole value is fraction
      end
      else
      begin
         t_int     = sign_1 ? (~t_mag + 32'd1) : t_mag;
         t_inexact = |mant_shift[fp_cvt_pkg::mant_w-1:0];
      end
   end

   // ********************
   // stage 2 registers
   // ********************
   always_ff @(posedge clk)
   begin
      if (reset)
         valid_2 <= 1'b0;
      else
         valid_2 <= valid_1;
   end

   always_ff @(posedge clk)
   begin
      op_2            <= op_1;
      trunc_2         <= t_int;
      trunc_invalid_2 <= t_invalid;
      trunc_inexact_2 <= t_inexact;
   end

endmodule

// File: fp_trunc/int32_to_fp.sv
`timescale 1ns/100ps

module int32_to_fp (
   input  logic                clk,
   input  logic                reset,
   input  fp_cvt_pkg::cvt_op_t op_1,
   input  logic [31:0]         int_1,
   output logic [63:0]         fp_2,
   output logic                fp_inexact_2
);

   logic                                sign;
   logic [31:0]                         mag;
   logic                                is_zero;
   logic [4:0]                          lead;      // position of leading one
   logic [31:0]                         norm;

   logic [fp_cvt_pkg::dp_exp_w-1:0]     d_exp;
   logic [fp_cvt_pkg::dp_frac_w-1:0]    d_frac;

   logic [fp_cvt_pkg::sp_frac_w-1:0]    s_trunc;
   logic                                s_guard;
   logic                                s_sticky;
   logic                                s_round_up;
   logic [fp_cvt_pkg::sp_frac_w:0]      s_sum;
   logic [fp_cvt_pkg::sp_exp_w-1:0]     s_exp;
   logic [fp_cvt_pkg::sp_frac_w-1:0]    s_frac;
   logic                                s_lost;

   // ********************
   // magnitude and normalize
   // ********************
   always_comb
   begin
      sign    = int_1[31];
      mag     = sign ? (~int_1 + 32'd1) : int_1;   // 80000000 stays as is
      is_zero = (int_1 == '0);

      lead = '0;
      for (int i = 0; i < 32; i++)
      begin
         if (mag[i])
            lead = 5'(i);
      end

      norm = mag << (5'd31 - lead);   // leading one at bit 31
   end

   // double holds every int32 exactly
   always_comb
   begin
      d_exp  = fp_cvt_pkg::dp_exp_w'(lead) + fp_cvt_pkg::dp_exp_w'(fp_cvt_pkg::dp_bias);
      d_frac = {norm[30:0], {(fp_cvt_pkg::dp_frac_w - 31){1'b0}}};
      if (is_zero)
      begin
         d_exp  = '0;
         d_frac = '0;
      end
   end

   // single rounds to nearest even
   always_comb
   begin
      s_trunc    = norm[30:8];
      s_guard    = norm[7];
      s_sticky   = |norm[6:0];
      s_round_up = s_guard && (s_sticky || s_trunc[0]);
      s_sum      = {1'b0, s_trunc} + {{fp_cvt_pkg::sp_frac_w{1'b0}}, s_round_up};
      s_frac     = s_sum[fp_cvt_pkg::sp_frac_w-1:0];   // wraps to zero on carry
      s_exp      = fp_cvt_pkg::sp_exp_w'(lead)
                   + fp_cvt_pkg::sp_exp_w'(fp_cvt_pkg::sp_bias)
                   + fp_cvt_pkg::sp_exp_w'(s_sum[fp_cvt_pkg::sp_frac_w]);
      s_lost     = s_guard || s_sticky;
      if (is_zero)
      begin
         s_exp  = '0;
         s_frac = '0;
         s_lost = 1'b0;
      end
   end

   // ********************
   // stage 2 registers
   // ********************
   always_ff @(posedge clk)
   begin
      if (op_1 == fp_cvt_pkg::cvt_d_w)
         fp_2 <= {sign, d_exp, d_frac};
      else
         fp_2 <= {32'd0, sign, s_exp, s_frac};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         fp_inexact_2 <= 1'b0;
      else
         fp_inexact_2 <= (op_1 == fp_cvt_pkg::cvt_s_w) && s_lost;
   end

endmodule

// File: src/fp_cvt_result.sv
`timescale 1ns/100ps

module fp_cvt_result (
   input  logic                clk,
   input  logic                reset,
   input  logic                valid_2,
   input  fp_cvt_pkg::cvt_op_t op_2,
   input  logic [31:0]         trunc_2,
   input  logic                trunc_invalid_2,
   input  logic                trunc_inexact_2,
   input  logic [63:0]         fp_2,
   input  logic                fp_inexact_2,
   output logic                valid,
   output logic [63:0]         result,
   output logic [1:0]          flags
);

   logic [63:0] next_result;
   logic [1:0]  next_flags;

   always_comb
   begin
      next_flags = '0;
      case (op_2)
         fp_cvt_pkg::trunc_w_s,
         fp_cvt_pkg::trunc_w_d:
         begin
            next_result                          = {32'd0, trunc_2};
            next_flags[fp_cvt_pkg::flag_invalid] = trunc_invalid_2;
            next_flags[fp_cvt_pkg::flag_inexact] = trunc_inexact_2;
         end
         default:
         begin
            // int to fp never raises invalid
            next_result                          = fp_2;
            next_flags[fp_cvt_pkg::flag_inexact] = fp_inexact_2;
         end
      endcase
   end

   // ********************
   // output registers
   // ********************
   always_ff @(posedge clk)
   begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= valid_2;
   end

   always_ff @(posedge clk)
   begin
      result <= next_result;
      flags  <= next_flags;
   end

endmodule

// File: src/fp_cvt_unit.sv
`timescale 1ns/100ps

module fp_cvt_unit (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    en,
   input  fp_cvt_pkg::cvt_op_t     op,
   input  fp_cvt_pkg::fp_operand_t operand,
   output logic                    valid,
   output logic [63:0]             result,
   output logic [1:0]              flags
);

   // stage 1
   logic                                 valid_1;
   fp_cvt_pkg::cvt_op_t                  op_1;
   logic                                 sign_1;
   logic signed [fp_cvt_pkg::uexp_w-1:0] exp_1;
   logic [fp_cvt_pkg::mant_w-1:0]        mant_1;
   logic                                 is_zero_1;
   logic                                 is_special_1;
   logic [31:0]                          int_1;

   // stage 2
   logic                                 valid_2;
   fp_cvt_pkg::cvt_op_t                  op_2;
   logic [31:0]                          trunc_2;
   logic                                 trunc_invalid_2;
   logic                                 trunc_inexact_2;
   logic [63:0]                          fp_2;
   logic                                 fp_inexact_2;

   fp_unpack fp_unpack_inst (
      .clk          (clk),
      .reset        (reset),
      .en           (en),
      .op           (op),
      .operand      (operand),
      .valid_1      (valid_1),
      .op_1         (op_1),
      .sign_1       (sign_1),
      .exp_1        (exp_1),
      .mant_1       (mant_1),
      .is_zero_1    (is_zero_1),
      .is_special_1 (is_special_1),
      .int_1        (int_1)
   );

   fp_trunc_to_int32 fp_trunc_to_int32_inst (
      .clk             (clk),
      .reset           (reset),
      .valid_1         (valid_1),
      .op_1            (op_1),
      .sign_1          (sign_1),
      .exp_1           (exp_1),
      .mant_1          (mant_1),
      .is_zero_1       (is_zero_1),
      .is_special_1    (is_special_1),
      .valid_2         (valid_2),
      .op_2            (op_2),
      .trunc_2         (trunc_2),
      .trunc_invalid_2 (trunc_invalid_2),
      .trunc_inexact_2 (trunc_inexact_2)
   );

   int32_to_fp int32_to_fp_inst (
      .clk          (clk),
      .reset        (reset),
      .op_1         (op_1),
      .int_1        (int_1),
      .fp_2         (fp_2),
      .fp_inexact_2 (fp_inexact_2)
   );

   fp_cvt_result fp_cvt_result_inst (
      .clk             (clk),
      .reset           (reset),
      .valid_2         (valid_2),
      .op_2            (op_2),
      .trunc_2         (trunc_2),
      .trunc_invalid_2 (trunc_invalid_2),
      .trunc_inexact_2 (trunc_inexact_2),
      .fp_2            (fp_2),
      .fp_inexact_2    (fp_inexact_2),
      .valid           (valid),
      .result          (result),
      .flags           (flags)
   );

endmodule

// File: bench/tb_fp_cvt_ref.svh
`ifndef TB_FP_CVT_REF_SVH
`define TB_FP_CVT_REF_SVH

// ********************
// expected results, packed as {flags, result}
// ********************

// float to int32, rounding toward zero
function automatic logic [65:0] truncate_value(input logic is_double, input logic [63:0] word);
   logic        sign;
   logic        field_zero;
   logic        field_ones;
   int          e;
   int          fw;
   logic [63:0] mant;
   logic [63:0] mag;
   logic [31:0] value;
   logic [1:0]  flags;
   flags = '0;
   if (is_double)
   begin
      sign       = word[63];
      field_zero = (word[62:52] == '0);
      field_ones = &word[62:52];
      e          = int'(word[62:52]) - fp_cvt_pkg::dp_bias;
      mant       = {11'd0, 1'b1, word[51:0]};
      fw         = fp_cvt_pkg::dp_frac_w;
   end
   else
   begin
      sign       = word[31];
      field_zero = (word[30:23] == '0);
      field_ones = &word[30:23];
      e          = int'(word[30:23]) - fp_cvt_pkg::sp_bias;
      mant       = {40'd0, 1'b1, word[22:0]};
      fw         = fp_cvt_pkg::sp_frac_w;
   end
   if (field_ones || (!field_zero && e >= 31))
   begin
      flags[fp_cvt_pkg::flag_invalid] = 1'b1;
      return {flags, 32'd0, fp_cvt_pkg::int_max};
   end
   if (field_zero)
      return '0;   // zero and flushed subnormals
   if (e < 0)
   begin
      flags[fp_cvt_pkg::flag_inexact] = 1'b1;
      return {flags, 64'd0};
   end
   if (e >= fw)
      mag = mant << (e - fw);
   else
   begin
      mag = mant >> (fw - e);
      flags[fp_cvt_pkg::flag_inexact] = ((mant & ((64'd1 << (fw - e)) - 64'd1)) != 64'd0);
   end
   value = sign ? (32'd0 - mag[31:0]) : mag[31:0];
   return {flags, 32'd0, value};
endfunction

// int32 to float, nearest even for single
function automatic logic [65:0] float_from_int(input logic is_double, input logic [31:0] x);
   logic        sign;
   logic [31:0] mag;
   logic [63:0] wide;
   logic [31:0] kept;
   logic [31:0] rem;
   logic [31:0] half;
   logic [1:0]  flags;
   int          p;
   int          sh;
   flags = '0;
   if (x == 32'd0)
      return '0;
   sign = x[31];
   mag  = sign ? (32'd0 - x) : x;
   p    = 31;
   while (!mag[p])
      p--;
   if (is_double)
   begin
      wide = {32'd0, mag} << (52 - p);
      return {flags, sign, 11'(p + fp_cvt_pkg::dp_bias), wide[51:0]};
   end
   rem = '0;
   if (p <= 23)
      kept = mag << (23 - p);
   else
   begin
      sh   = p - 23;
      kept = mag >> sh;
      rem  = mag & ((32'd1 << sh) - 32'd1);
      half = 32'd1 << (sh - 1);
      if (rem > half || (rem == half && kept[0]))
         kept = kept + 32'd1;
      if (kept[24])
      begin
         kept = kept >> 1;   // carry into the exponent
         p++;
      end
   end
   flags[fp_cvt_pkg::flag_inexact] = (rem != 32'd0);
   return {flags, 32'd0, sign, 8'(p + fp_cvt_pkg::sp_bias), kept[22:0]};
endfunction

function automatic logic [65:0] predict(input fp_cvt_pkg::cvt_op_t o, input logic [63:0] word);
   case (o)
      fp_cvt_pkg::trunc_w_s: return truncate_value(1'b0, word);
      fp_cvt_pkg::trunc_w_d: return truncate_value(1'b1, word);
      fp_cvt_pkg::cvt_s_w:   return float_from_int(1'b0, word[31:0]);
      default:               return float_from_int(1'b1, word[31:0]);
   endcase
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

`endif

// File: bench/tb_fp_cvt.sv
`timescale 1ns/100ps

module tb_fp_cvt;

   `include "tb_fp_cvt_ref.svh"

   localparam int clk_period = 40;
   localparam int n_directed = 35;
   localparam int n_random   = 400;
   localparam int latency    = 3;
   localparam longint watchdog_ns = longint'((n_directed + n_random) * 2 + 50) * clk_period;

   typedef struct packed {
      logic [63:0] result;
      logic [1:0]  flags;
      logic [31:0] due;
   } expect_t;

   logic                    clk = 1'b0;
   logic                    reset;
   logic                    en;
   fp_cvt_pkg::cvt_op_t     op;
   fp_cvt_pkg::fp_operand_t operand;
   logic                    valid;
   logic [63:0]             result;
   logic [1:0]              flags;

   expect_t     exp_q[$];
   int          cycle = 0;
   logic [31:0] rng_state = 32'd91;

   always #(clk_period / 2) clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   fp_cvt_unit fp_cvt_unit_inst (
      .clk     (clk),
      .reset   (reset),
      .en      (en),
      .op      (op),
      .operand (operand),
      .valid   (valid),
      .result  (result),
      .flags   (flags)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
      if (got !== want)
         fail_run($sformatf("Error: %s is %h, expected %h", name, got, want));
   endtask

   task automatic issue_op(input fp_cvt_pkg::cvt_op_t o, input logic [63:0] word);
      logic [65:0] pred;
      expect_t     item;
      @(posedge clk);
      en      <= 1'b1;
      op      <= o;
      operand <= word;
      pred        = predict(o, word);
      item.result = pred[63:0];
      item.flags  = pred[65:64];
      item.due    = 32'(cycle + 1 + latency);   // en is taken at the next edge
      exp_q.push_back(item);
   endtask

   task automatic idle_cycle;
      @(posedge clk);
      en <= 1'b0;
   endtask

   // ********************
   // directed operands
   // ********************
   task automatic run_directed;
      issue_op(fp_cvt_pkg::trunc_w_s, 64'hdeadbeef_3f800000);   // upper half ignored
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_bfc00000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_3f000000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_80000000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_4b7fffff);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_4effffff);
      idle_cycle;
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_4f000000);   // 2^31
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_7f800000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_7fc00000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h00000000_ff800000);
      issue_op(fp_cvt_pkg::trunc_w_s, 64'h12345678_c2f6e979);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h3ff00000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'hc00c0000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h3fe00000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h41dfffff_ffc00000);   // int max, exact
      issue_op(fp_cvt_pkg::trunc_w_d, 64'hc1e00000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h41e00000_00000000);
      idle_cycle;
      idle_cycle;
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h7ff00000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h7ff80000_00000000);
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h00000000_00000001);   // subnormal
      issue_op(fp_cvt_pkg::trunc_w_d, 64'h41dfffff_ffffffff);
      issue_op(fp_cvt_pkg::cvt_d_w, 64'h0);
      issue_op(fp_cvt_pkg::cvt_d_w, 64'h00000001);
      issue_op(fp_cvt_pkg::cvt_d_w, 64'hffffffff);
      issue_op(fp_cvt_pkg::cvt_d_w, 64'h80000000);
      issue_op(fp_cvt_pkg::cvt_d_w, 64'h7fffffff);
      idle_cycle;
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h0);
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h00ffffff);
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h01000001);   // tie, stays even
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h01000003);   // tie, rounds up
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h7fffffff);   // carries into exponent
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h80000000);
      issue_op(fp_cvt_pkg::cvt_s_w, 64'h01000002);
      issue_op(fp_cvt_pkg::cvt_s_w, 64'hffffff85);
   endtask

   task automatic issue_random;
      logic [31:0]             r0;
      logic [31:0]             r1;
      logic [31:0]             r2;
      fp_cvt_pkg::fp_operand_t w;
      fp_cvt_pkg::cvt_op_t     o;
      rng_state = xorshift32(rng_state);
      r0        = rng_state;
      rng_state = xorshift32(rng_state);
      r1        = rng_state;
      rng_state = xorshift32(rng_state);
      r2        = rng_state;
      o = fp_cvt_pkg::cvt_op_t'(r0[1:0]);
      w = {r1, r2};
      // steer most exponents near the int32 range
      case (o)
         fp_cvt_pkg::trunc_w_s:
            if (r0[4:2] != 3'd0)
               w.s.exp = 8'(fp_cvt_pkg::sp_bias - 4 + int'(r0[10:5]) % 38);
         fp_cvt_pkg::trunc_w_d:
            if (r0[4:2] != 3'd0)
               w.d.exp = 11'(fp_cvt_pkg::dp_bias - 4 + int'(r0[10:5]) % 38);
         default:
            if (r0[4:2] == 3'd0)
               w[31:0] = r1 >> r0[9:5];
      endcase
      issue_op(o, w);
   endtask

   // ********************
   // compare
   // ********************
   always @(negedge clk)
   begin : compare
      expect_t front;
      if (!reset)
      begin
         if (valid === 1'b1)
         begin
            if (exp_q.size() == 0)
               fail_run("valid went high with no operation outstanding");
            else
            begin
               front = exp_q.pop_front();
               check_value("valid cycle", 64'(cycle), 64'(front.due));
               check_value("result", result, front.result);
               check_value("flags", 64'(flags), 64'(front.flags));
            end
         end
         else if (valid !== 1'b0)
            fail_run("valid is unknown after reset");
         else if (exp_q.size() != 0 && exp_q[0].due <= 32'(cycle))
            fail_run("valid did not arrive for an issued operation");
      end
   end

   initial
   begin
      #(watchdog_ns);
      fail_run("simulation timed out before all results arrived");
   end

   initial
   begin
      int issued;
      int drain;
      reset   = 1'b1;
      en      = 1'b0;
      op      = fp_cvt_pkg::trunc_w_s;
      operand = '0;
      issued  = 0;
      drain   = 0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      idle_cycle;
      idle_cycle;
      run_directed;
      while (issued < n_random)
      begin
         rng_state = xorshift32(rng_state);
         if (rng_state[1:0] != 2'd0)
         begin
            issue_random;
            issued++;
         end
         else
            idle_cycle;
      end
      idle_cycle;
      while (exp_q.size() != 0 && drain < latency + 4)
      begin
         @(posedge clk);
         drain++;
      end
      repeat (2) @(posedge clk);   // stray valids show up here
      if (exp_q.size() != 0)
         fail_run($sformatf("%0d operations never produced a result", exp_q.size()));
      else
      begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// File: sources.f
+incdir+bench
common/fp_cvt_pkg.sv
fp_trunc/fp_unpack.sv
fp_trunc/fp_trunc_to_int32.sv
fp_trunc/int32_to_fp.sv
src/fp_cvt_result.sv
src/fp_cvt_unit.sv
bench/tb_fp_cvt.sv

// File: run_sim.sh
#!/bin/sh
# Build the fp_cvt testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_fp_cvt -o tb_fp_cvt_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_fp_cvt_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
